// ==== l1_dcache.f ====
common/cache_pkg.sv
common/mem_op_pkg.sv
logic/lsu_align.sv
cache/cache_core.sv
logic/main_memory.sv
logic/l1_dcache_top.sv
verif/l1_dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the l1_dcache testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f l1_dcache.f \
    --top-module l1_dcache_tb \
    -o l1_dcache_sim

./obj_dir/l1_dcache_sim > sim.log
cat sim.log

grep -q "PASS: all tests" sim.log

// ==== verif/l1_dcache_tb.sv ====
`timescale 1ns/1ps

module l1_dcache_tb import mem_op_pkg::*, cache_pkg::*; ();

    localparam int N_RESET     = NUM_SETS;
    localparam int N_SIZE      = 33;
    localparam int N_LRU       = 7;
    localparam int N_WB        = 10;
    localparam int N_RANDOM    = 2000;
    localparam int TOTAL_REQS  = N_RESET + N_SIZE + N_LRU + N_WB + N_RANDOM;
    localparam int CYCLE_LIMIT = (TOTAL_REQS * 3) / 2 + 50;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    cpu_req_t req;
    logic     hit;
    data_t    load_data;

    // reference state of flat memory plus tag, valid and lru per way
    data_t  mem_m   [MEM_WORDS];
    tag_t   tag_m   [NUM_SETS][NUM_WAYS];
    logic   valid_m [NUM_SETS][NUM_WAYS];
    logic   lru_m   [NUM_SETS][NUM_WAYS];

    integer seed;
    int     errors;
    int     checks;
    int     req_count;
    int     cycles;
    int     err_base;

    l1_dcache_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .hit       (hit),
        .load_data (load_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] byte_addr(tag_t t, set_t s, logic [1:0] off);
        return {20'd0, t, s, off};
    endfunction

    // expected load value from the model word
    function automatic data_t expected_load(data_t word, access_size_e size, logic [1:0] low);
        data_t lane;
        data_t result;
        case (size)
            SIZE_BYTE, SIZE_BYTE_U: lane = word >> (8 * int'(low));
            SIZE_HALF, SIZE_HALF_U: lane = word >> (16 * int'(low[1]));
            default:                lane = word;
        endcase
        case (size)
            SIZE_BYTE:   result = {{24{lane[7]}}, lane[7:0]};
            SIZE_HALF:   result = {{16{lane[15]}}, lane[15:0]};
            SIZE_BYTE_U: result = {24'd0, lane[7:0]};
            SIZE_HALF_U: result = {16'd0, lane[15:0]};
            default:     result = lane;
        endcase
        return result;
    endfunction

    function automatic data_t store_merge(data_t old, access_size_e size, logic [1:0] low,
                                          data_t wdata);
        data_t result;
        result = old;
        case (size)
            SIZE_BYTE, SIZE_BYTE_U: result[8*int'(low) +: 8] = wdata[7:0];
            SIZE_HALF, SIZE_HALF_U: result[16*int'(low[1]) +: 16] = wdata[15:0];
            default:                result = wdata;
        endcase
        return result;
    endfunction

    task automatic send_req(logic write, access_size_e size, logic [31:0] addr, data_t wdata);
        cpu_req_t r;
        r.write = write;
        r.size  = size;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= r;
    endtask

    task automatic end_test(string name);
        @(posedge clk);
        req_valid <= 1'b0;
        $display("test %s done, %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    task automatic loads_all_sizes(tag_t t, set_t s);
        for (int off = 0; off < 4; off++) begin
            send_req(1'b0, SIZE_BYTE, byte_addr(t, s, 2'(off)), '0);
            send_req(1'b0, SIZE_BYTE_U, byte_addr(t, s, 2'(off)), '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            send_req(1'b0, SIZE_HALF, byte_addr(t, s, 2'(off)), '0);
            send_req(1'b0, SIZE_HALF_U, byte_addr(t, s, 2'(off)), '0);
        end
        send_req(1'b0, SIZE_WORD, byte_addr(t, s, 2'd0), '0);
        send_req(1'b0, SIZE_HALF, byte_addr(t, s, 2'd3), '0);   // misaligned half
        send_req(1'b0, SIZE_WORD, byte_addr(t, s, 2'd1), '0);   // misaligned word
    endtask

    task automatic random_traffic();
        logic [31:0]  r_addr;
        logic [31:0]  r_ctl;
        logic [31:0]  r_data;
        access_size_e sz;
        for (int i = 0; i < N_RANDOM; i++) begin
            r_addr = $random(seed);
            r_ctl  = $random(seed);
            r_data = $random(seed);
            case (int'(r_ctl[15:8]) % 5)
                0:       sz = SIZE_BYTE;
                1:       sz = SIZE_HALF;
                2:       sz = SIZE_WORD;
                3:       sz = SIZE_BYTE_U;
                default: sz = SIZE_HALF_U;
            endcase
            // four tags over four sets with aliasing upper bits
            send_req(r_ctl[16], sz, {r_addr[31:12], 4'b0000, r_ctl[1:0], 2'b00, r_ctl[3:2],
                                     r_ctl[5:4]}, r_data);
        end
    endtask

    // compare process sampled mid-cycle
    always @(negedge clk) begin : check_responses
        word_addr_t wa;
        set_t       s;
        tag_t       t;
        logic       exp_hit;
        logic       way;
        data_t      exp_data;
        if (rst_n && req_valid) begin
            wa       = req.addr[11:2];
            s        = wa[SET_BITS-1:0];
            t        = wa[ADDR_BITS-1:SET_BITS];
            exp_hit  = (valid_m[s][0] && tag_m[s][0] == t) || (valid_m[s][1] && tag_m[s][1] == t);
            exp_data = expected_load(mem_m[wa], req.size, req.addr[1:0]);
            if (valid_m[s][1] && tag_m[s][1] == t) way = 1'b1;
            else if (valid_m[s][0] && tag_m[s][0] == t) way = 1'b0;
            else if (lru_m[s][0] && !lru_m[s][1]) way = 1'b1;   // way 1 is the victim
            else way = 1'b0;
            req_count++;
            checks++;
            assert (hit === exp_hit) else begin
                $display("MISMATCH %0t: hit %0b, expected %0b, addr %h", $time, hit, exp_hit,
                         req.addr);
                errors++;
            end
            if (!req.write) begin
                checks++;
                assert (load_data === exp_data) else begin
                    $display("MISMATCH %0t: load_data %h, expected %h, addr %h size %0d",
                             $time, load_data, exp_data, req.addr, req.size);
                    errors++;
                end
            end
            if (req.write) mem_m[wa] = store_merge(mem_m[wa], req.size, req.addr[1:0], req.wdata);
            valid_m[s][way] = 1'b1;
            tag_m[s][way]   = t;
            lru_m[s][way]   = 1'b1;
            lru_m[s][!way]  = 1'b0;
        end else if (rst_n) begin
            checks++;
            assert (hit === 1'b0) else begin
                $display("MISMATCH %0t: hit high while idle", $time);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        seed      = 32'h6219c667;
        errors    = 0;
        checks    = 0;
        req_count = 0;
        cycles    = 0;
        err_base  = 0;
        for (int i = 0; i < MEM_WORDS; i++) mem_m[i] = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                tag_m[s][w]   = '0;
                valid_m[s][w] = 1'b0;
                lru_m[s][w]   = 1'b0;
            end
        end
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int s = 0; s < NUM_SETS; s++) begin
            send_req(1'b0, SIZE_WORD, byte_addr(tag_t'(s), set_t'(s), 2'b00), '0);
        end
        end_test("reset_misses");

        send_req(1'b1, SIZE_WORD, byte_addr(6'd1, 4'd2, 2'd0), 32'h8091_a2f3);
        loads_all_sizes(6'd1, 4'd2);
        send_req(1'b1, SIZE_BYTE, byte_addr(6'd1, 4'd2, 2'd1), 32'h0000_0085);
        send_req(1'b1, SIZE_HALF, byte_addr(6'd1, 4'd2, 2'd2), 32'h0000_fe01);
        loads_all_sizes(6'd1, 4'd2);
        end_test("size_extension");

        send_req(1'b0, SIZE_WORD, byte_addr(6'd10, 4'd5, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd10, 4'd5, 2'd0), '0);   // hit
        send_req(1'b0, SIZE_WORD, byte_addr(6'd11, 4'd5, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd10, 4'd5, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd12, 4'd5, 2'd0), '0);   // evicts tag 11
        send_req(1'b0, SIZE_WORD, byte_addr(6'd11, 4'd5, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd12, 4'd5, 2'd0), '0);
        end_test("lru_eviction");

        send_req(1'b1, SIZE_WORD, byte_addr(6'd20, 4'd9, 2'd0), 32'hdead_beef);
        send_req(1'b1, SIZE_BYTE, byte_addr(6'd21, 4'd9, 2'd3), 32'h0000_00c4);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd22, 4'd9, 2'd0), '0);   // dirty eviction
        send_req(1'b0, SIZE_WORD, byte_addr(6'd23, 4'd9, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd20, 4'd9, 2'd0), '0);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd21, 4'd9, 2'd0), '0);
        send_req(1'b0, SIZE_BYTE_U, byte_addr(6'd21, 4'd9, 2'd3), '0);
        send_req(1'b0, SIZE_HALF, byte_addr(6'd20, 4'd9, 2'd2), '0);
        send_req(1'b1, SIZE_HALF, byte_addr(6'd22, 4'd9, 2'd2), 32'h0000_9a5c);
        send_req(1'b0, SIZE_WORD, byte_addr(6'd22, 4'd9, 2'd0), '0);
        end_test("dirty_writeback");

        random_traffic();
        end_test("random_traffic");

        $display("summary: %0d requests, %0d checks, %0d errors", req_count, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== logic/l1_dcache_top.sv ====
`timescale 1ns/1ps

module l1_dcache_top import mem_op_pkg::*, cache_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  cpu_req_t req,
    output logic     hit,
    output data_t    load_data
);

    logic       acc_valid;
    logic       acc_write;
    word_addr_t acc_addr;
    byte_mask_t acc_mask;
    data_t      acc_wdata;
    data_t      read_word;
    word_addr_t fill_addr;
    data_t      fill_data;
    mem_wr_t    wb;

    lsu_align u_align (
        .req       (req),
        .req_valid (req_valid),
        .read_word (read_word),
        .acc_valid (acc_valid),
        .acc_write (acc_write),
        .acc_addr  (acc_addr),
        .acc_mask  (acc_mask),
        .acc_wdata (acc_wdata),
        .load_data (load_data)
    );

    cache_core u_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_valid (acc_valid),
        .acc_write (acc_write),
        .acc_addr  (acc_addr),
        .acc_mask  (acc_mask),
        .acc_wdata (acc_wdata),
        .fill_data (fill_data),
        .hit       (hit),
        .read_word (read_word),
        .fill_addr (fill_addr),
        .wb        (wb)
    );

    main_memory u_mem (
        .clk       (clk),
        .fill_addr (fill_addr),
        .wb        (wb),
        .fill_data (fill_data)
    );

endmodule

// ==== logic/main_memory.sv ====
`timescale 1ns/1ps

module main_memory import mem_op_pkg::*, cache_pkg::*; (
    input  logic       clk,
    input  word_addr_t fill_addr,
    input  mem_wr_t    wb,
    output data_t      fill_data
);

    data_t mem [MEM_WORDS];

    // memory starts out all zero
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign fill_data = mem[fill_addr];   // no read latency

    always_ff @(posedge clk) begin
        if (wb.en) begin
            mem[wb.addr] <= wb.data;   // eviction lands at the edge
        end
    end

endmodule

// ==== cache/cache_core.sv ====
`timescale 1ns/1ps

module cache_core import mem_op_pkg::*, cache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       acc_valid,
    input  logic       acc_write,
    input  word_addr_t acc_addr,
    input  byte_mask_t acc_mask,
    input  data_t      acc_wdata,
    input  data_t      fill_data,
    output logic       hit,
    output data_t      read_word,
    output word_addr_t fill_addr,
    output mem_wr_t    wb
);

    cache_line_t lines [NUM_SETS][NUM_WAYS];

    set_t                set_idx;
    tag_t                req_tag;
    logic [NUM_WAYS-1:0] way_hit;
    logic                hit_way;
    logic                victim_way;
    logic                use_way;       // way written this cycle
    cache_line_t         hit_line;
    cache_line_t         victim_line;
    data_t               base_word;     // hit data or fill data
    data_t               merged_word;
    cache_line_t         new_line;

    assign set_idx = acc_addr[SET_BITS-1:0];
    assign req_tag = acc_addr[ADDR_BITS-1:SET_BITS];

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = lines[set_idx][w].valid && (lines[set_idx][w].tag == req_tag);
        end
    end

    assign hit     = acc_valid && (|way_hit);
    assign hit_way = way_hit[1];

    // victim is the way whose lru bit is clear, way 0 unless only way 1 is clear
    assign victim_way = lines[set_idx][0].lru & ~lines[set_idx][1].lru;
    assign use_way    = hit ? hit_way : victim_way;

    assign hit_line    = lines[set_idx][hit_way];
    assign victim_line = lines[set_idx][victim_way];

    assign base_word = hit ? hit_line.data : fill_data;
    assign read_word = base_word;
    assign fill_addr = acc_addr;   // memory is always read at the request

    // store bytes over the current word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[b*8 +: 8] = acc_mask[b] ? acc_wdata[b*8 +: 8] : base_word[b*8 +: 8];
        end
    end

    // dirty victim goes back on any miss
    always_comb begin
        wb.en   = acc_valid && !hit && victim_line.valid && victim_line.dirty;
        wb.addr = {victim_line.tag, set_idx};
        wb.data = victim_line.data;
    end

    always_comb begin
        new_line.valid = 1'b1;
        new_line.dirty = acc_write | (hit & hit_line.dirty);   // read fill comes in clean
        new_line.lru   = 1'b1;
        new_line.tag   = req_tag;
        new_line.data  = acc_write ? merged_word : base_word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    lines[s][w] <= '0;
                end
            end
        end else if (acc_valid) begin
            lines[set_idx][use_way]      <= new_line;
            lines[set_idx][~use_way].lru <= 1'b0;   // other way becomes lru
        end
    end

endmodule

// ==== logic/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align import mem_op_pkg::*, cache_pkg::*; (
    input  cpu_req_t   req,
    input  logic       req_valid,
    input  data_t      read_word,
    output logic       acc_valid,
    output logic       acc_write,
    output word_addr_t acc_addr,
    output byte_mask_t acc_mask,
    output data_t      acc_wdata,
    output data_t      load_data
);

    logic [1:0] byte_off;    // aligned lane offset
    data_t      lane_word;   // addressed bytes moved to lane 0

    assign acc_valid = req_valid;
    assign acc_write = req_valid & req.write;
    assign acc_addr  = req.addr[11:2];

    // misaligned accesses fall back to the natural boundary
    always_comb begin
        case (req.size)
            SIZE_BYTE, SIZE_BYTE_U: byte_off = req.addr[1:0];
            SIZE_HALF, SIZE_HALF_U: byte_off = {req.addr[1], 1'b0};
            default:                byte_off = 2'b00;
        endcase
    end

    always_comb begin
        case (req.size)
            SIZE_BYTE, SIZE_BYTE_U: begin
                acc_mask  = byte_mask_t'(4'b0001 << byte_off);
                acc_wdata = {4{req.wdata[7:0]}};    // byte in every lane
            end
            SIZE_HALF, SIZE_HALF_U: begin
                acc_mask  = byte_mask_t'(4'b0011 << byte_off);
                acc_wdata = {2{req.wdata[15:0]}};
            end
            default: begin
                acc_mask  = 4'b1111;
                acc_wdata = req.wdata;
            end
        endcase
    end

    assign lane_word = read_word >> {byte_off, 3'b000};

    // extract and extend for loads
    always_comb begin
        case (req.size)
            SIZE_BYTE:   load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            SIZE_HALF:   load_data = {{16{lane_word[15]}}, lane_word[15:0]};
            SIZE_BYTE_U: load_data = {24'd0, lane_word[7:0]};
            SIZE_HALF_U: load_data = {16'd0, lane_word[15:0]};
            default:     load_data = read_word;   // word and unused codes
        endcase
    end

endmodule

// ==== common/mem_op_pkg.sv ====
package mem_op_pkg;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_mask_t;   // one enable per byte lane

    // load/store width and extension encoded as funct3
    typedef enum logic [2:0] {
        SIZE_BYTE   = 3'b000,
        SIZE_HALF   = 3'b001,
        SIZE_WORD   = 3'b010,
        SIZE_BYTE_U = 3'b100,
        SIZE_HALF_U = 3'b101
    } access_size_e;

    // request from the load/store port
    typedef struct packed {
        logic         write;
        access_size_e size;
        logic [31:0]  addr;     // byte address with upper bits ignored
        data_t        wdata;    // store value in the low lanes
    } cpu_req_t;

    // write-back of an evicted dirty line
    typedef struct packed {
        logic                  en;
        cache_pkg::word_addr_t addr;
        data_t                 data;
    } mem_wr_t;

endpackage

// ==== common/cache_pkg.sv ====
package cache_pkg;

    // geometry of the line store and the backing memory
    localparam int NUM_SETS  = 16;
    localparam int NUM_WAYS  = 2;
    localparam int MEM_WORDS = 1024;

    localparam int WORD_BITS = 32;     // one data word per line
    localparam int ADDR_BITS = 10;     // byte address bits 11:2
    localparam int SET_BITS  = 4;
    localparam int TAG_BITS  = ADDR_BITS - SET_BITS;

    // word address split as {tag, set}
    typedef logic [ADDR_BITS-1:0] word_addr_t;
    typedef logic [SET_BITS-1:0]  set_t;
    typedef logic [TAG_BITS-1:0]  tag_t;

    typedef logic [WORD_BITS-1:0] line_data_t;

    // one way of one set
    typedef struct packed {
        logic       valid;
        logic       dirty;
        logic       lru;         // set on use, cleared on the other way
        tag_t       tag;
        line_data_t data;
    } cache_line_t;

endpackage
